/* Bender.yml */
package:
  name: hc595_panel

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hc595_pkg.sv
      - rtl/ctrl_word_sync.sv
      - rtl/hc595_loader.sv
      - rtl/hc595_analog_driver.sv
      - rtl/hc595_panel_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/tb_hc595_panel.sv

/* rtl/ctrl_word_sync.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hc595_defs.svh"

module ctrl_word_sync (
	input  wire                       clk_1M_buf,
	input  wire                       rst_n,
	input  hc595_pkg::ctrl_word_t     i_control,
	input  hc595_pkg::analog_word_t   i_analog,
	output hc595_pkg::ctrl_word_t     o_control,
	output hc595_pkg::analog_word_t   o_analog
);

	// Both words travel side by side through one crossing
	localparam int W = $bits(hc595_pkg::ctrl_word_t) + $bits(hc595_pkg::analog_word_t);

	logic [`SYNC_STAGES-1:0][W-1:0] sync_q;
	logic [W-1:0]                   sample_q;
	logic [W-1:0]                   hold_q;
	logic [W-1:0]                   sync_out;
	logic                           stable;

	assign sync_out = sync_q[`SYNC_STAGES-1];

	// Two back-to-back samples equal, so no bit is still in flight
	assign stable = (sync_out == sample_q);

	//////////////////////////////////////////////////////////////////////
	// Synchronizer chain and stability filter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_1M_buf or negedge rst_n) begin
		if (!rst_n) begin
			sync_q   <= '0;
			sample_q <= '0;
			hold_q   <= '0;
		end else begin
			sync_q   <= {sync_q[`SYNC_STAGES-2:0], {i_control, i_analog}};
			sample_q <= sync_out;
			if (stable) begin
				hold_q <= sync_out;
			end
		end
	end

	// Split back into the two words
	assign {o_control, o_analog} = hold_q;

endmodule

`default_nettype wire

/* rtl/hc595_analog_driver.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hc595_defs.svh"

module hc595_analog_driver (
	input  wire                      clk_1M_buf,
	input  wire                      rst_n,
	input  hc595_pkg::analog_word_t  i_analog,
	output hc595_pkg::hc595_pins_t   o_pins,
	output logic                     o_oe_n
);

	logic [`ANALOG_CHAIN_BITS-1:0] frame;
	logic                          latched;

	// Switch map over both devices, upper five outputs unused
	assign frame = {
		5'b0_0000,
		i_analog.vx_vr_amp,
		i_analog.bias_on,
		i_analog.measure_sel,
		i_analog.rr_sel,
		i_analog.vr_sel
	};

	hc595_loader #(
		.WIDTH (`ANALOG_CHAIN_BITS)
	) u_loader (
		.clk_1M_buf (clk_1M_buf),
		.rst_n      (rst_n),
		.i_frame    (frame),
		.o_pins     (o_pins),
		.o_latched  (latched)
	);

	//////////////////////////////////////////////////////////////////////
	// Output enable
	//////////////////////////////////////////////////////////////////////

	// Switches stay open until the chain holds a known pattern
	always_ff @(posedge clk_1M_buf or negedge rst_n) begin
		if (!rst_n) begin
			o_oe_n <= 1'b1;
		end else if (latched) begin
			o_oe_n <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/hc595_defs.svh */
`ifndef HC595_DEFS_SVH
`define HC595_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// 74HC595 chain geometry
//////////////////////////////////////////////////////////////////////

// Parallel outputs on one device
`define HC595_CHIP_BITS 8

// Attenuator chains, one device each
`define ATT_CHAIN_BITS (1 * `HC595_CHIP_BITS)

// Gain chain, one device
`define AMP_CHAIN_BITS (1 * `HC595_CHIP_BITS)

// Analog switch chain, two devices in cascade
`define ANALOG_CHAIN_BITS (2 * `HC595_CHIP_BITS)

//////////////////////////////////////////////////////////////////////
// Clock domain crossing
//////////////////////////////////////////////////////////////////////

// Flops between the processor-side words and clk_1M_buf
`define SYNC_STAGES 2

`endif

/* rtl/hc595_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module hc595_loader #(
	parameter int WIDTH = 8
) (
	input  wire                     clk_1M_buf,
	input  wire                     rst_n,
	input  wire  [WIDTH-1:0]        i_frame,
	output hc595_pkg::hc595_pins_t  o_pins,
	output logic                    o_latched
);

	localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

	// Frame last sent to the chain
	logic [WIDTH-1:0] last_q;
	// Bits still to go, MSB drives ser
	logic [WIDTH-1:0] shift_q;
	logic [CNT_W-1:0] cnt_q;

	logic             busy_q;
	// Low half of a bit period when 0, srclk high when 1
	logic             phase_q;
	// Forces one load after reset
	logic             first_q;

	logic             srclr_n_q;
	logic             rclk_q;
	logic             srclk_q;
	logic             start;

	// Only an idle loader may pick up a new frame
	assign start = !busy_q && (first_q || (i_frame != last_q));

	//////////////////////////////////////////////////////////////////////
	// Serial shift sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_1M_buf or negedge rst_n) begin
		if (!rst_n) begin
			last_q    <= '0;
			shift_q   <= '0;
			cnt_q     <= '0;
			busy_q    <= 1'b0;
			phase_q   <= 1'b0;
			first_q   <= 1'b1;
			srclr_n_q <= 1'b0;
			rclk_q    <= 1'b0;
			srclk_q   <= 1'b0;
		end else begin
			// Chain clear released on the first clock
			srclr_n_q <= 1'b1;
			rclk_q    <= 1'b0;

			if (start) begin
				last_q  <= i_frame;
				shift_q <= i_frame;
				cnt_q   <= '0;
				busy_q  <= 1'b1;
				phase_q <= 1'b0;
				first_q <= 1'b0;
				srclk_q <= 1'b0;
			end else if (busy_q && !phase_q) begin
				// ser has settled, clock it in
				srclk_q <= 1'b1;
				phase_q <= 1'b1;
			end else if (busy_q) begin
				srclk_q <= 1'b0;
				phase_q <= 1'b0;
				shift_q <= {shift_q[WIDTH-2:0], 1'b0};
				if (cnt_q == CNT_W'(WIDTH - 1)) begin
					// Last bit in, move it to the outputs
					busy_q <= 1'b0;
					rclk_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	assign o_pins = '{
		srclr_n: srclr_n_q,
		rclk:    rclk_q,
		srclk:   srclk_q,
		ser:     shift_q[WIDTH-1]
	};

	assign o_latched = rclk_q;

endmodule

`default_nettype wire

/* rtl/hc595_panel_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hc595_defs.svh"

module hc595_panel_top (
	input  wire                      clk_1M_buf,
	input  wire                      rst_n,
	input  hc595_pkg::ctrl_word_t    i_control,
	input  hc595_pkg::analog_word_t  i_analog,
	output hc595_pkg::hc595_pins_t   o_amp,
	output hc595_pkg::hc595_pins_t   o_att_a,
	output hc595_pkg::hc595_pins_t   o_att_b,
	output hc595_pkg::hc595_pins_t   o_analog,
	output logic                     o_analog_oe_n
);

	hc595_pkg::ctrl_word_t    ctrl_s;
	hc595_pkg::analog_word_t  analog_s;

	logic [`AMP_CHAIN_BITS-1:0] amp_frame;
	logic [`ATT_CHAIN_BITS-1:0] att_a_frame;
	logic [`ATT_CHAIN_BITS-1:0] att_b_frame;

	//////////////////////////////////////////////////////////////////////
	// Processor words into the 1 MHz domain
	//////////////////////////////////////////////////////////////////////

	ctrl_word_sync u_sync (
		.clk_1M_buf (clk_1M_buf),
		.rst_n      (rst_n),
		.i_control  (i_control),
		.i_analog   (i_analog),
		.o_control  (ctrl_s),
		.o_analog   (analog_s)
	);

	// Frame packing
	assign amp_frame   = {ctrl_s.amp_b, ctrl_s.amp_a};
	assign att_a_frame = {4'b0000, ctrl_s.att_a};
	assign att_b_frame = {4'b0000, ctrl_s.att_b};

	//////////////////////////////////////////////////////////////////////
	// Shift-register chains
	//////////////////////////////////////////////////////////////////////

	hc595_loader #(.WIDTH(`AMP_CHAIN_BITS)) u_amp (
		.clk_1M_buf (clk_1M_buf),
		.rst_n      (rst_n),
		.i_frame    (amp_frame),
		.o_pins     (o_amp),
		.o_latched  ()
	);

	hc595_loader #(.WIDTH(`ATT_CHAIN_BITS)) u_att_a (
		.clk_1M_buf (clk_1M_buf),
		.rst_n      (rst_n),
		.i_frame    (att_a_frame),
		.o_pins     (o_att_a),
		.o_latched  ()
	);

	hc595_loader #(.WIDTH(`ATT_CHAIN_BITS)) u_att_b (
		.clk_1M_buf (clk_1M_buf),
		.rst_n      (rst_n),
		.i_frame    (att_b_frame),
		.o_pins     (o_att_b),
		.o_latched  ()
	);

	// Analog switches, has its own OE pin
	hc595_analog_driver u_analog (
		.clk_1M_buf (clk_1M_buf),
		.rst_n      (rst_n),
		.i_analog   (analog_s),
		.o_pins     (o_analog),
		.o_oe_n     (o_analog_oe_n)
	);

endmodule

`default_nettype wire

/* rtl/hc595_pkg.sv */
`default_nettype none

package hc595_pkg;

	// Processor control word, amp_a sits in the lowest nibble
	typedef struct packed {
		logic [9:0] reserved;
		// Lock-in filter fields, not used on this path
		logic [1:0] lpf_mode;
		logic [3:0] lpf_coe;
		// Attenuator settings
		logic [3:0] att_b;
		logic [3:0] att_a;
		// Gain settings
		logic [3:0] amp_b;
		logic [3:0] amp_a;
	} ctrl_word_t;

	// Analog switch control word
	typedef struct packed {
		logic       vx_vr_amp;
		logic       bias_on;
		// Frequency switch, handled elsewhere
		logic [1:0] freq_switch;
		logic [3:0] measure_sel;
		logic [2:0] rr_sel;
		logic [1:0] vr_sel;
	} analog_word_t;

	// Pins of one 74HC595 chain
	typedef struct packed {
		logic srclr_n;
		logic rclk;
		logic srclk;
		logic ser;
	} hc595_pins_t;

endpackage

`default_nettype wire

/* testbench/tb_hc595_panel.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hc595_defs.svh"

// Behavioral 74HC595 chain that shifts on SRCLK and latches on RCLK
module hc595_chain_model #(
	parameter int WIDTH = 8
) (
	input  hc595_pkg::hc595_pins_t i_pins,
	output logic [WIDTH-1:0]       o_latch,
	output int                     o_latch_count
);

	logic [WIDTH-1:0] sr;
	wire              srclk = i_pins.srclk;
	wire              rclk = i_pins.rclk;
	wire              srclr_n = i_pins.srclr_n;

	initial o_latch_count = 0;

	always @(posedge srclk or negedge srclr_n) begin
		if (!srclr_n) begin
			sr <= '0;
		end else begin
			sr <= {sr[WIDTH-2:0], i_pins.ser};
		end
	end

	always @(posedge rclk) begin
		o_latch       <= sr;
		o_latch_count <= o_latch_count + 1;
	end

endmodule

module tb_hc595_panel;

	localparam int QUIET_CYCLES = 8;
	localparam int WAIT_LIMIT   = 200;
	localparam int LOADS        = 12;
	// Six tests of up to 20 loads, 40 cycles per load at 4 ns
	localparam int WATCHDOG_NS  = 6 * 20 * 40 * 4;

	logic                          clk_1M_buf;
	logic                          rst_n;
	hc595_pkg::ctrl_word_t         i_control;
	hc595_pkg::analog_word_t       i_analog;
	hc595_pkg::hc595_pins_t        amp_pins;
	hc595_pkg::hc595_pins_t        att_a_pins;
	hc595_pkg::hc595_pins_t        att_b_pins;
	hc595_pkg::hc595_pins_t        analog_pins;
	logic                          analog_oe_n;

	logic [`AMP_CHAIN_BITS-1:0]    amp_latch;
	logic [`ATT_CHAIN_BITS-1:0]    att_a_latch;
	logic [`ATT_CHAIN_BITS-1:0]    att_b_latch;
	logic [`ANALOG_CHAIN_BITS-1:0] analog_latch;
	int                            amp_count;
	int                            att_a_count;
	int                            att_b_count;
	int                            analog_count;

	integer                        seed;
	int                            errors;
	int                            test_errors;
	int                            tests_run;
	int                            tests_failed;
	int                            oe_high_cycles;
	int                            count_before;
	hc595_pkg::ctrl_word_t         ctrl;
	hc595_pkg::analog_word_t       an;

	hc595_panel_top u_dut (
		.clk_1M_buf    (clk_1M_buf),
		.rst_n         (rst_n),
		.i_control     (i_control),
		.i_analog      (i_analog),
		.o_amp         (amp_pins),
		.o_att_a       (att_a_pins),
		.o_att_b       (att_b_pins),
		.o_analog      (analog_pins),
		.o_analog_oe_n (analog_oe_n)
	);

	hc595_chain_model #(.WIDTH(`AMP_CHAIN_BITS)) amp_model (
		.i_pins        (amp_pins),
		.o_latch       (amp_latch),
		.o_latch_count (amp_count)
	);
	hc595_chain_model #(.WIDTH(`ATT_CHAIN_BITS)) att_a_model (
		.i_pins        (att_a_pins),
		.o_latch       (att_a_latch),
		.o_latch_count (att_a_count)
	);
	hc595_chain_model #(.WIDTH(`ATT_CHAIN_BITS)) att_b_model (
		.i_pins        (att_b_pins),
		.o_latch       (att_b_latch),
		.o_latch_count (att_b_count)
	);
	hc595_chain_model #(.WIDTH(`ANALOG_CHAIN_BITS)) analog_model (
		.i_pins        (analog_pins),
		.o_latch       (analog_latch),
		.o_latch_count (analog_count)
	);

	initial begin
		clk_1M_buf = 1'b0;
		forever begin
			#2 clk_1M_buf = ~clk_1M_buf;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the test sequence reached its end");
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and waiting
	//////////////////////////////////////////////////////////////////////

	function automatic hc595_pkg::ctrl_word_t random_ctrl();
		random_ctrl = $random(seed);
	endfunction

	function automatic hc595_pkg::analog_word_t random_analog();
		logic [31:0] r;
		r = $random(seed);
		random_analog = r[12:0];
	endfunction

	task automatic drive_words(input hc595_pkg::ctrl_word_t c, input hc595_pkg::analog_word_t a);
		@(posedge clk_1M_buf);
		i_control <= c;
		i_analog  <= a;
	endtask

	// Idle means no SRCLK or RCLK activity on any chain for a while
	task automatic wait_quiet(input string what);
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < QUIET_CYCLES && waited < WAIT_LIMIT) begin
			@(negedge clk_1M_buf);
			waited++;
			if (amp_pins.srclk || amp_pins.rclk || att_a_pins.srclk || att_a_pins.rclk ||
				att_b_pins.srclk || att_b_pins.rclk || analog_pins.srclk || analog_pins.rclk) begin
				quiet = 0;
			end else begin
				quiet++;
			end
			// Switches stay disconnected until the analog chain has latched once
			if (analog_count == 0) begin
				check_level(analog_oe_n, 1'b1, "oe_n before first latch");
			end
			if (analog_oe_n) begin
				oe_high_cycles++;
			end
		end
		if (quiet < QUIET_CYCLES) begin
			$display("Chains were still shifting %0d cycles after the %s update", waited, what);
			errors++;
		end
	endtask

	task automatic wait_load_start();
		int waited;
		waited = 0;
		while (!analog_pins.srclk && waited < WAIT_LIMIT) begin
			@(negedge clk_1M_buf);
			waited++;
		end
		if (!analog_pins.srclk) begin
			$display("The analog chain never started shifting after its word changed");
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_level(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("ERROR %0t: %s is %b, expected %b", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic compare_att(input hc595_pkg::ctrl_word_t c);
		logic [`ATT_CHAIN_BITS-1:0] exp_a;
		logic [`ATT_CHAIN_BITS-1:0] exp_b;
		exp_a = {4'b0000, c.att_a};
		exp_b = {4'b0000, c.att_b};
		if (att_a_latch !== exp_a || att_b_latch !== exp_b) begin
			$display("ERROR %0t: attenuators latched %h/%h, expected %h/%h", $time,
				att_a_latch, att_b_latch, exp_a, exp_b);
			errors++;
		end
	endtask

	task automatic compare_amp(input hc595_pkg::ctrl_word_t c);
		logic [`AMP_CHAIN_BITS-1:0] exp_amp;
		exp_amp = {c.amp_b, c.amp_a};
		if (amp_latch !== exp_amp) begin
			$display("ERROR %0t: amplifier latched %h, expected %h", $time, amp_latch, exp_amp);
			errors++;
		end
	endtask

	task automatic compare_analog(input hc595_pkg::analog_word_t a);
		logic [`ANALOG_CHAIN_BITS-1:0] exp_an;
		exp_an = {5'b0_0000, a.vx_vr_amp, a.bias_on, a.measure_sel, a.rr_sel, a.vr_sel};
		if (analog_latch !== exp_an) begin
			$display("ERROR %0t: analog chain latched %h, expected %h", $time,
				analog_latch, exp_an);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_errors);
		end else begin
			$display("test %s: ok", name);
		end
		test_errors = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'hf1873cf5;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		oe_high_cycles = 0;
		rst_n = 1'b0;
		i_control = '0;
		i_analog = '0;
		ctrl = '0;
		an = '0;

		repeat (4) @(posedge clk_1M_buf);
		@(negedge clk_1M_buf);
		check_level(|{amp_pins.srclr_n, att_a_pins.srclr_n, att_b_pins.srclr_n,
			analog_pins.srclr_n}, 1'b0, "srclr_n during reset");
		check_level(analog_oe_n, 1'b1, "oe_n during reset");
		@(posedge clk_1M_buf);
		rst_n <= 1'b1;
		@(negedge clk_1M_buf);
		check_level(|{amp_pins.srclr_n, att_a_pins.srclr_n, att_b_pins.srclr_n,
			analog_pins.srclr_n}, 1'b0, "srclr_n in first cycle");
		@(negedge clk_1M_buf);
		check_level(&{amp_pins.srclr_n, att_a_pins.srclr_n, att_b_pins.srclr_n,
			analog_pins.srclr_n}, 1'b1, "srclr_n after first cycle");
		wait_quiet("reset");
		compare_att('0);
		compare_amp('0);
		compare_analog('0);
		check_level(analog_oe_n, 1'b0, "oe_n after first latch");
		end_test("reset");

		repeat (LOADS) begin
			ctrl = random_ctrl();
			drive_words(ctrl, an);
			wait_quiet("attenuator");
			compare_att(ctrl);
		end
		end_test("attenuators");

		repeat (LOADS) begin
			ctrl = random_ctrl();
			drive_words(ctrl, an);
			wait_quiet("amplifier");
			compare_amp(ctrl);
			// Changing only the lock-in fields must leave the gain chain idle
			count_before = amp_count;
			ctrl.reserved = ~ctrl.reserved;
			ctrl.lpf_mode = ~ctrl.lpf_mode;
			ctrl.lpf_coe  = ~ctrl.lpf_coe;
			drive_words(ctrl, an);
			wait_quiet("unused field");
			check_count(amp_count, count_before, "amplifier loads after lpf change");
			compare_amp(ctrl);
		end
		end_test("amplifier");

		repeat (LOADS) begin
			an = random_analog();
			drive_words(ctrl, an);
			wait_quiet("analog");
			compare_analog(an);
			count_before = analog_count;
			an.freq_switch = ~an.freq_switch;
			drive_words(ctrl, an);
			wait_quiet("freq_switch");
			check_count(analog_count, count_before, "analog loads after freq_switch change");
			compare_analog(an);
		end
		end_test("analog");

		oe_high_cycles = 0;
		repeat (LOADS) begin
			an = random_analog();
			drive_words(ctrl, an);
			wait_quiet("output enable");
			compare_analog(an);
		end
		check_count(oe_high_cycles, 0, "cycles with oe_n high");
		end_test("oe");

		repeat (4) begin
			// Flip vr_sel so the analog chain surely starts a load
			an.vr_sel = ~an.vr_sel;
			ctrl = random_ctrl();
			drive_words(ctrl, an);
			wait_load_start();
			repeat (3) begin
				repeat (3) @(posedge clk_1M_buf);
				ctrl = random_ctrl();
				an = random_analog();
				drive_words(ctrl, an);
			end
			wait_quiet("mid-load");
			compare_att(ctrl);
			compare_amp(ctrl);
			compare_analog(an);
		end
		end_test("mid-load");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/hc595_pkg.sv
rtl/ctrl_word_sync.sv
rtl/hc595_loader.sv
rtl/hc595_analog_driver.sv
rtl/hc595_panel_top.sv
testbench/tb_hc595_panel.sv
